/* src.f */
verilog/cpuPkg.sv
verilog/registerFile.sv
verilog/alu.sv
verilog/psrReg.sv
verilog/bram.sv
verilog/datapath.sv
sim/datapathTb.sv

/* Bender.yml */
package:
  name: datapath

sources:
  - verilog/cpuPkg.sv
  - verilog/registerFile.sv
  - verilog/alu.sv
  - verilog/psrReg.sv
  - verilog/bram.sv
  - verilog/datapath.sv
  - target: simulation
    files:
      - sim/datapathTb.sv

/* sim/datapathTb.sv */
// ====================
// datapathTb
// random-stimulus testbench for the datapath,
// cycle model of regs, RAM, psr, leds and pc
// ====================

`timescale 1ns/1ps

module datapathTb
	import cpuPkg::*;
();

	logic                clk;
	logic                arstN;
	ctrlT                ctrl;
	logic [wordBits-1:0] loadData;
	logic [wordBits-1:0] switches;
	logic [wordBits-1:0] pc;
	instrU               instr;
	logic [wordBits-1:0] aluOut;
	psrT                 flags;
	logic [ledBits-1:0]  leds;

	logic [31:0]         lfsr;
	logic [15:0]         mRegs [16];    // model register file
	logic [15:0]         mRam [1024];   // model RAM, unknown until written
	psrT                 mPsr;
	logic [ledBits-1:0]  mLeds;
	logic [15:0]         mPc;
	instrU               mInstr;
	logic [15:0]         mQa;           // registered port reads
	logic [15:0]         mQb;
	logic [15:0]         prog [12];

	datapath UUT (
		.clk     (clk),
		.arstN   (arstN),
		.ctrl    (ctrl),
		.loadData(loadData),
		.switches(switches),
		.pc      (pc),
		.instr   (instr),
		.aluOut  (aluOut),
		.flags   (flags),
		.leds    (leds)
	);

	always #20 clk = ~clk;  // 40 ns period

	task automatic stopRun();
		$display("sim failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic checkWord(input string name, input logic [15:0] got, input logic [15:0] exp);
		if (got !== exp) begin
			$display("[ERROR] t=%0t %s got %h expected %h", $time, name, got, exp);
			stopRun();
		end
	endtask

	task automatic checkFlags(input psrT got, input psrT exp);
		if (got !== exp) begin
			$display("[ERROR] t=%0t flags got %b expected %b", $time, got, exp);
			stopRun();
		end
	endtask

	task automatic checkInstr(input instrU got, input instrU exp);
		if (got !== exp) begin
			$display("[ERROR] t=%0t instr got %h expected %h", $time, got, exp);
			stopRun();
		end
	endtask

	task automatic checkLeds(input logic [ledBits-1:0] got, input logic [ledBits-1:0] exp);
		if (got !== exp) begin
			$display("[ERROR] t=%0t leds got %h expected %h", $time, got, exp);
			stopRun();
		end
	endtask

	// taps 32 22 2 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] randBits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsrNext(lfsr);
			r    = {r[30:0], lfsr[0]};  // one step per bit
		end
		return r;
	endfunction

	function automatic aluOpE randOp();
		logic [3:0] v;
		v = randBits(4) % 9;  // only the defined opcodes
		return aluOpE'(v);
	endfunction

	// reference ALU, integer arithmetic for carry and overflow
	function automatic void modelAlu(input aluOpE op, input logic [15:0] a, input logic [15:0] b,
		output logic [15:0] r, output psrT f);
		int ua;
		int ub;
		int sa;
		int sb;
		ua = a;
		ub = b;
		sa = $signed(a);
		sb = $signed(b);
		r  = '0;
		f  = '0;
		case (op)
			aluAdd: begin
				r             = a + b;
				f.g1.carry    = (ua + ub) > 65535;
				f.g1.overflow = (sa + sb > 32767) || (sa + sb < -32768);
			end
			aluSub: begin
				r             = a - b;
				f.g1.carry    = ua < ub;
				f.g1.overflow = (sa - sb > 32767) || (sa - sb < -32768);
				f.g2.lower    = ua < ub;
			end
			aluAnd: r = a & b;
			aluOr:  r = a | b;
			aluXor: r = a ^ b;
			aluNot: r = ~b;
			aluCmp: begin
				r             = b - a;
				f.g1.carry    = ub < ua;
				f.g1.overflow = (sb - sa > 32767) || (sb - sa < -32768);
			end
			aluMov: r = b;
			aluLsh: r = b[4] ? (a >> b[3:0]) : (a << b[3:0]);
			default: r = '0;
		endcase
		if (op == aluCmp) begin
			f.g2.zero     = (a == b);
			f.g2.negative = sb < sa;
			f.g2.lower    = ub < ua;
		end else begin
			f.g2.zero     = (r == 16'h0000);
			f.g2.negative = r[15];
		end
	endfunction

	// entered 2 ns after an edge, leaves 2 ns after the next one
	task automatic runCycle(input ctrlT c, input logic [15:0] ld);
		logic [3:0]  dst;
		logic [3:0]  src;
		logic [15:0] r1;
		logic [15:0] r2;
		logic [15:0] opA;
		logic [15:0] opB;
		logic [15:0] expOut;
		logic [15:0] wd;
		logic [15:0] np;
		logic [15:0] newQa;
		logic [15:0] newQb;
		psrT         expFlags;
		ctrl     = c;
		loadData = ld;
		#10;  // well before the edge
		dst = mInstr.rForm.dst;
		src = mInstr.rForm.src;
		r1  = mRegs[dst];
		r2  = mRegs[src];
		case (c.a2Sel)
			2'd1:    opB = {12'h000, src};
			2'd2:    opB = {{8{mInstr.iForm.imm[7]}}, mInstr.iForm.imm};
			default: opB = r2;
		endcase
		opA = c.luiSel ? {mInstr.iForm.imm, 8'h00} : r1;
		modelAlu(c.aluOp, opA, opB, expOut, expFlags);
		checkWord("aluOut", aluOut, expOut);
		case (c.rwSel)
			2'd1:    wd = mPc + 16'd1;  // link
			2'd2:    wd = c.movSel ? expOut : opB;
			default: wd = mQb;
		endcase
		case (c.pcSel)
			2'd1:    np = r1;
			2'd2:    np = expOut;
			default: np = mPc + 16'd1;
		endcase
		newQa = c.memAEn ? ld : mRam[mPc[9:0]];
		if (r2 == ioAddr) newQb = switches;
		else newQb = c.memBEn ? r1 : mRam[r2[9:0]];
		@(posedge clk);
		#2;
		if (c.memAEn) mRam[mPc[9:0]] = ld;
		if (c.memBEn && r2 != ioAddr) mRam[r2[9:0]] = r1;
		if (c.memBEn && r2 == ioAddr) mLeds = r1[ledBits-1:0];
		if (c.rfEn) mRegs[dst] = wd;
		if (c.psrEn) mPsr = expFlags;
		if (c.pcEn) mPc = np;
		if (c.irEn) mInstr = mQa;  // the old port A read
		mQa = newQa;
		mQb = newQb;
		checkWord("pc", pc, mPc);
		checkInstr(instr, mInstr);
		checkFlags(flags, mPsr);
		checkLeds(leds, mLeds);
	endtask

	// write a word at pc, then load it into the IR
	task automatic loadInstr(input logic [15:0] word);
		ctrlT c;
		c        = '0;
		c.memAEn = 1'b1;
		runCycle(c, word);
		c      = '0;
		c.irEn = 1'b1;
		runCycle(c, 16'h0000);
	endtask

	// lui form gives (imm << 8) + imm[3:0], plain form the sign-extended imm
	task automatic writeImm(input logic [3:0] d, input logic [7:0] imm, input logic lui);
		ctrlT c;
		loadInstr({4'h0, d, imm});
		c        = '0;
		c.rfEn   = 1'b1;
		c.rwSel  = 2'd2;
		c.luiSel = lui;
		c.a2Sel  = lui ? 2'd1 : 2'd2;
		c.movSel = lui;
		runCycle(c, 16'h0000);
	endtask

	task automatic readBack(input logic [3:0] r);
		ctrlT c;
		loadInstr({12'h000, r});
		c       = '0;
		c.aluOp = aluMov;  // aluOut shows the src register
		runCycle(c, 16'h0000);
	endtask

	initial begin
		ctrlT       c;
		logic [3:0] d;
		logic [3:0] e;
		logic [3:0] f;
		int         n;
		clk      = 1'b0;
		arstN    = 1'b0;
		ctrl     = '0;
		loadData = '0;
		switches = '0;
		lfsr     = 32'h4ce;
		for (int i = 0; i < 16; i++) mRegs[i] = '0;
		mPsr   = '0;
		mLeds  = '0;
		mPc    = '0;
		mInstr = '0;
		mQa    = 'x;
		mQb    = 'x;
		repeat (10) @(posedge clk);
		#2;
		arstN = 1'b1;
		n     = 0;
		while (!(pc === 16'h0000 && instr === 16'h0000 && flags === 5'b0)) begin
			if (n == 16) begin
				$display("datapath did not come out of reset in 16 cycles");
				stopRun();
			end
			@(posedge clk);
			#2;
			n++;
		end

		// program load at stepping pc, then back to 0 through r0
		for (int i = 0; i < 12; i++) begin
			c        = '0;
			c.memAEn = 1'b1;
			c.pcEn   = 1'b1;
			prog[i]  = randBits(16);
			runCycle(c, prog[i]);
		end
		c       = '0;
		c.pcEn  = 1'b1;
		c.pcSel = 2'd1;
		runCycle(c, 16'h0000);
		for (int i = 0; i < 12; i++) begin
			c = '0;
			runCycle(c, 16'h0000);  // pc stable, port A reads
			c.irEn = 1'b1;
			c.pcEn = 1'b1;
			runCycle(c, 16'h0000);
			checkInstr(instr, prog[i]);
		end

		// seed a few registers so ALU ops see real operands
		for (int i = 0; i < 8; i++) writeImm(randBits(4), randBits(8), randBits(1));

		// register and immediate ALU ops, psr hold, writeback
		for (int i = 0; i < 40; i++) begin
			loadInstr(randBits(16));
			c        = '0;
			c.aluOp  = randOp();
			c.a2Sel  = randBits(2) % 3;
			c.luiSel = randBits(1);
			c.movSel = randBits(1);
			c.psrEn  = randBits(1);
			c.rfEn   = 1'b1;
			c.rwSel  = 2'd2;
			runCycle(c, 16'h0000);
			c.rfEn  = 1'b0;
			c.psrEn = 1'b0;  // flags must hold while aluOut moves
			c.aluOp = randOp();
			runCycle(c, 16'h0000);
			readBack(mInstr.rForm.dst);
		end

		// RAM store then load through port B
		for (int i = 0; i < 8; i++) begin
			d = randBits(4);
			e = randBits(4);
			f = randBits(4);
			writeImm(d, randBits(8), 1'b1);  // address
			writeImm(e, randBits(8), 1'b1);  // data
			loadInstr({4'h0, e, 4'h0, d});
			c        = '0;
			c.memBEn = 1'b1;
			runCycle(c, 16'h0000);
			loadInstr({4'h0, f, 4'h0, d});
			c = '0;
			runCycle(c, 16'h0000);
			c.rfEn = 1'b1;
			runCycle(c, 16'h0000);  // rwSel 0 takes memB
			readBack(f);
		end

		// ioAddr, leds on store and switches on load
		for (int i = 0; i < 4; i++) begin
			d = randBits(4);
			e = d + 4'd1;
			f = randBits(4);
			writeImm(e, randBits(8), 1'b1);
			writeImm(d, 8'hFF, 1'b0);  // sign extends to ioAddr
			loadInstr({4'h0, e, 4'h0, d});
			c        = '0;
			c.memBEn = 1'b1;
			runCycle(c, 16'h0000);
			switches = randBits(16);
			loadInstr({4'h0, f, 4'h0, d});
			c = '0;
			runCycle(c, 16'h0000);
			c.rfEn = 1'b1;
			runCycle(c, 16'h0000);
			readBack(f);
		end

		// jumps and link
		for (int i = 0; i < 6; i++) begin
			d = randBits(4);
			writeImm(d, randBits(8), 1'b1);
			loadInstr({4'h0, d, 8'h00});
			c       = '0;
			c.pcEn  = 1'b1;
			c.pcSel = 2'd1;
			runCycle(c, 16'h0000);
			loadInstr(randBits(16));
			c       = '0;
			c.aluOp = randOp();
			c.a2Sel = 2'd2;
			c.pcEn  = 1'b1;
			c.pcSel = 2'd2;
			runCycle(c, 16'h0000);
			loadInstr({4'h0, d, 8'h00});
			c       = '0;
			c.rfEn  = 1'b1;
			c.rwSel = 2'd1;
			runCycle(c, 16'h0000);
			readBack(d);
		end

		$display("sim passed");
		$finish;
	end

endmodule

/* verilog/datapath.sv */
// ====================
// datapath
// 16-bit datapath top: pc, ir, operand muxes,
// register file, ALU, psr and block RAM
// ====================

`timescale 1ns/1ps

module datapath
	import cpuPkg::*;
(
	input  logic                clk,
	input  logic                arstN,
	input  ctrlT                ctrl,      // driven by tb until a controller exists
	input  logic [wordBits-1:0] loadData,  // program data via port A
	input  logic [wordBits-1:0] switches,
	output logic [wordBits-1:0] pc,
	output instrU               instr,
	output logic [wordBits-1:0] aluOut,
	output psrT                 flags,
	output logic [ledBits-1:0]  leds
);

	logic [wordBits-1:0] pcPlus1;
	logic [wordBits-1:0] pcMuxOut;
	logic [wordBits-1:0] rfRead1;   // dst register
	logic [wordBits-1:0] rfRead2;   // src register
	logic [wordBits-1:0] rfWrite;
	logic [wordBits-1:0] memA;
	logic [wordBits-1:0] memB;
	logic [wordBits-1:0] a2MuxOut;
	logic [wordBits-1:0] luiMuxOut;
	logic [wordBits-1:0] movMuxOut;
	logic [wordBits-1:0] srcZext;
	logic [wordBits-1:0] immSext;
	logic [wordBits-1:0] luiImm;
	psrT                 aluFlags;

	assign pcPlus1 = pc + 16'd1;

	// immediates, the 4-bit src field and the 8-bit imm
	assign srcZext = {12'b0, instr.rForm.src};
	assign immSext = {{8{instr.iForm.imm[7]}}, instr.iForm.imm};
	assign luiImm  = {instr.iForm.imm, 8'h00};

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pc    <= '0;
			instr <= '0;
		end else begin
			if (ctrl.pcEn) pc <= pcMuxOut;
			if (ctrl.irEn) instr <= memA;  // memA lags pc by one edge
		end
	end

	always_comb begin
		case (ctrl.pcSel)
			2'd1:    pcMuxOut = rfRead1;  // jump to register
			2'd2:    pcMuxOut = aluOut;   // computed target
			default: pcMuxOut = pcPlus1;
		endcase
	end

	always_comb begin
		case (ctrl.a2Sel)
			2'd1:    a2MuxOut = srcZext;
			2'd2:    a2MuxOut = immSext;
			default: a2MuxOut = rfRead2;
		endcase
	end

	assign luiMuxOut = ctrl.luiSel ? luiImm : rfRead1;
	assign movMuxOut = ctrl.movSel ? aluOut : a2MuxOut;

	// writeback select, load / link / move
	always_comb begin
		case (ctrl.rwSel)
			2'd1:    rfWrite = pcPlus1;
			2'd2:    rfWrite = movMuxOut;
			default: rfWrite = memB;
		endcase
	end

	registerFile regFile (
		.clk      (clk),
		.arstN    (arstN),
		.writeEn  (ctrl.rfEn),
		.writeAddr(instr.rForm.dst),
		.writeData(rfWrite),
		.readAddr1(instr.rForm.dst),
		.readAddr2(instr.rForm.src),
		.readData1(rfRead1),
		.readData2(rfRead2)
	);

	alu myAlu (
		.aluOp (ctrl.aluOp),
		.aluIn1(luiMuxOut),
		.aluIn2(a2MuxOut),
		.aluOut(aluOut),
		.flags (aluFlags)
	);

	psrReg psr (
		.clk     (clk),
		.arstN   (arstN),
		.en      (ctrl.psrEn),
		.flagsIn (aluFlags),
		.flagsOut(flags)
	);

	// port A fetch / program load, port B load / store through src
	bram ram (
		.clk     (clk),
		.arstN   (arstN),
		.weA     (ctrl.memAEn),
		.weB     (ctrl.memBEn),
		.addrA   (pc),
		.addrB   (rfRead2),
		.dataA   (loadData),
		.dataB   (rfRead1),
		.switches(switches),
		.qA      (memA),
		.qB      (memB),
		.leds    (leds)
	);

endmodule

/* verilog/bram.sv */
// ====================
// bram
// 1024-word dual-port RAM, registered reads,
// port B maps ioAddr to switches and leds
// ====================

`timescale 1ns/1ps

module bram
	import cpuPkg::*;
(
	input  logic                clk,
	input  logic                arstN,
	input  logic                weA,
	input  logic                weB,
	input  logic [wordBits-1:0] addrA,     // pc
	input  logic [wordBits-1:0] addrB,     // rf src value
	input  logic [wordBits-1:0] dataA,
	input  logic [wordBits-1:0] dataB,
	input  logic [wordBits-1:0] switches,
	output logic [wordBits-1:0] qA,
	output logic [wordBits-1:0] qB,
	output logic [ledBits-1:0]  leds
);

	logic [wordBits-1:0]    mem [2**memAddrBits];
	logic [memAddrBits-1:0] idxA;
	logic [memAddrBits-1:0] idxB;
	logic                   isIo;

	assign idxA = addrA[memAddrBits-1:0];  // upper bits ignored
	assign idxB = addrB[memAddrBits-1:0];
	assign isIo = (addrB == ioAddr);

	// both ports in one process, port B wins a same-address collision
	always_ff @(posedge clk) begin
		if (weA) begin
			mem[idxA] <= dataA;
		end
		if (weB && !isIo) begin
			mem[idxB] <= dataB;
		end
		qA <= weA ? dataA : mem[idxA];  // write-first
		if (isIo) begin
			qB <= switches;  // registered like a memory read
		end else begin
			qB <= weB ? dataB : mem[idxB];
		end
	end

	// led register, store to ioAddr
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			leds <= '0;
		end else if (weB && isIo) begin
			leds <= dataB[ledBits-1:0];
		end
	end

endmodule

/* verilog/psrReg.sv */
// ====================
// psrReg
// status register, latches ALU flags on en
// ====================

`timescale 1ns/1ps

module psrReg
	import cpuPkg::*;
(
	input  logic clk,
	input  logic arstN,
	input  logic en,        // psrEn from the control word
	input  psrT  flagsIn,
	output psrT  flagsOut
);

	// holds flags of the last enabled op for branch tests
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			flagsOut <= '0;
		end else if (en) begin
			flagsOut <= flagsIn;
		end
	end

endmodule

/* verilog/alu.sv */
// ====================
// alu
// combinational ALU, result plus both flag groups
// ====================

`timescale 1ns/1ps

module alu
	import cpuPkg::*;
(
	input  aluOpE               aluOp,
	input  logic [wordBits-1:0] aluIn1,  // A, usually rf dst
	input  logic [wordBits-1:0] aluIn2,  // B, usually rf src or imm
	output logic [wordBits-1:0] aluOut,
	output psrT                 flags
);

	logic [wordBits:0] sum;     // extra bit is carry out
	logic [wordBits:0] diffAB;  // extra bit is borrow
	logic [wordBits:0] diffBA;
	logic              ovfAdd;
	logic              ovfSub;
	logic              ovfCmp;

	assign sum    = {1'b0, aluIn1} + {1'b0, aluIn2};
	assign diffAB = {1'b0, aluIn1} - {1'b0, aluIn2};
	assign diffBA = {1'b0, aluIn2} - {1'b0, aluIn1};

	// signed overflow, sign of result disagrees with operands
	assign ovfAdd = (aluIn1[wordBits-1] == aluIn2[wordBits-1])
		&& (sum[wordBits-1] != aluIn1[wordBits-1]);
	assign ovfSub = (aluIn1[wordBits-1] != aluIn2[wordBits-1])
		&& (diffAB[wordBits-1] != aluIn1[wordBits-1]);
	assign ovfCmp = (aluIn2[wordBits-1] != aluIn1[wordBits-1])
		&& (diffBA[wordBits-1] != aluIn2[wordBits-1]);

	always_comb begin
		aluOut = '0;
		flags  = '0;  // logic ops leave carry / overflow clear
		case (aluOp)
			aluAdd: begin
				aluOut            = sum[wordBits-1:0];
				flags.g1.carry    = sum[wordBits];
				flags.g1.overflow = ovfAdd;
			end
			aluSub: begin
				aluOut            = diffAB[wordBits-1:0];  // A - B
				flags.g1.carry    = diffAB[wordBits];      // borrow
				flags.g1.overflow = ovfSub;
				flags.g2.lower    = diffAB[wordBits];      // result wrapped below zero
			end
			aluAnd: aluOut = aluIn1 & aluIn2;
			aluOr:  aluOut = aluIn1 | aluIn2;
			aluXor: aluOut = aluIn1 ^ aluIn2;
			aluNot: aluOut = ~aluIn2;  // unary, acts on B like mov
			aluCmp: begin
				aluOut            = diffBA[wordBits-1:0];  // B - A
				flags.g1.carry    = diffBA[wordBits];
				flags.g1.overflow = ovfCmp;
			end
			aluMov: aluOut = aluIn2;
			aluLsh: aluOut = aluIn2[4] ? (aluIn1 >> aluIn2[3:0])
				: (aluIn1 << aluIn2[3:0]);
			default: aluOut = '0;
		endcase

		// group 2 from the result, cmp overrides with the comparison
		if (aluOp == aluCmp) begin
			flags.g2.zero     = (aluIn1 == aluIn2);
			flags.g2.negative = ($signed(aluIn2) < $signed(aluIn1));
			flags.g2.lower    = (aluIn2 < aluIn1);
		end else begin
			flags.g2.zero     = (aluOut == '0);
			flags.g2.negative = aluOut[wordBits-1];
		end
	end

endmodule

/* verilog/registerFile.sv */
// ====================
// registerFile
// 16 x 16 registers, two async reads, one write
// ====================

`timescale 1ns/1ps

module registerFile
	import cpuPkg::*;
(
	input  logic                clk,
	input  logic                arstN,
	input  logic                writeEn,
	input  logic [3:0]          writeAddr,
	input  logic [wordBits-1:0] writeData,
	input  logic [3:0]          readAddr1,
	input  logic [3:0]          readAddr2,
	output logic [wordBits-1:0] readData1,
	output logic [wordBits-1:0] readData2
);

	logic [wordBits-1:0] regs [16];

	// all entries come up zero, r0 is not hardwired
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < 16; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn) begin
			regs[writeAddr] <= writeData;
		end
	end

	// no bypass, a same-cycle write shows up after the edge
	assign readData1 = regs[readAddr1];  // dst
	assign readData2 = regs[readAddr2];  // src

endmodule

/* verilog/cpuPkg.sv */
// ====================
// cpuPkg
// shared widths, ALU opcodes, flag, instruction
// and control word types for the datapath
// ====================

package cpuPkg;

	localparam int wordBits    = 16;        // data and address width
	localparam int memAddrBits = 10;        // 1024 words of block RAM
	localparam logic [15:0] ioAddr = 16'hFFFF; // switches on read, leds on write
	localparam int ledBits     = 10;

	typedef enum logic [3:0] {
		aluAdd = 4'd0,
		aluSub = 4'd1,
		aluAnd = 4'd2,
		aluOr  = 4'd3,
		aluXor = 4'd4,
		aluNot = 4'd5,
		aluCmp = 4'd6,  // B - A, flags only matter
		aluMov = 4'd7,  // pass B
		aluLsh = 4'd8   // B[4] picks direction
	} aluOpE;

	// group 1, arithmetic
	typedef struct packed {
		logic carry;
		logic overflow;
	} flags1T;

	// group 2, result / compare
	typedef struct packed {
		logic zero;
		logic negative;
		logic lower;     // unsigned less-than
	} flags2T;

	typedef struct packed {
		flags1T g1;
		flags2T g2;
	} psrT;

	typedef struct packed {
		logic [3:0] op;
		logic [3:0] dst;
		logic [3:0] opExt;
		logic [3:0] src;
	} instrRT;

	typedef struct packed {
		logic [3:0] op;
		logic [3:0] dst;
		logic [7:0] imm;
	} instrIT;

	// same word, register view or immediate view
	typedef union packed {
		instrRT rForm;
		instrIT iForm;
	} instrU;

	typedef struct packed {
		logic       memAEn;  // port A write at pc
		logic       memBEn;  // port B store
		logic       rfEn;
		logic       psrEn;
		logic       irEn;
		logic       pcEn;
		logic [1:0] pcSel;   // 0 pc+1, 1 rf dst, 2 aluOut
		logic [1:0] a2Sel;   // 0 rf src, 1 zext src field, 2 sext imm
		logic       luiSel;  // 0 rf dst, 1 imm << 8
		logic       movSel;  // 0 alu B operand, 1 aluOut
		logic [1:0] rwSel;   // 0 port B read, 1 pc+1, 2 move mux
		aluOpE      aluOp;
	} ctrlT;

endpackage
